// ==== src/decode_pkg.sv ====
// ****************************************
// 8086 decode package
// Instruction classes, field widths and ModR/M codes
// ****************************************
package decode_pkg;

    localparam int OPCODE_W = 8;           // Opcode byte
    localparam int MODRM_W  = 8;           // ModR/M byte
    localparam int REG_ID_W = 4;           // Top bit marks a segment register
    localparam int LEN_W    = 3;           // Length in bytes, 1 to 6

    localparam int MAX_INSN_LEN = 6;       // Opcode, ModR/M, disp16, imm16

    localparam logic [2:0] MODRM_DIRECT_RM = 3'b110;  // With mod 00 a direct address
    localparam logic [1:0] MOD_REG         = 2'b11;   // Register operand

    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [LEN_W-1:0]    insn_len_t;

    // Instruction classes kept by the decoder
    typedef enum logic [4:0] {
        CLS_ALU_RM,        // ADD..CMP R/M,R
        CLS_ALU_ACC_IMM,   // ADD..CMP ACC,IMM
        CLS_GRP1_RM_IMM,   // 80-83
        CLS_TEST_XCHG_RM,
        CLS_MOV_RM,
        CLS_MOV_SREG,      // 8C, 8E
        CLS_LEA,
        CLS_POP_RM,
        CLS_REG16,         // INC, DEC, PUSH, POP reg16 and XCHG ACC
        CLS_MOV_R_IMM,
        CLS_MOV_RM_IMM,
        CLS_SHIFT_RM,      // By 1 or CL
        CLS_SHIFT_RM_IMM,
        CLS_BR_SHORT,
        CLS_BR_NEAR,
        CLS_BR_FAR,        // Offset then segment
        CLS_MOV_ACC_MEM,
        CLS_RET_IMM,
        CLS_ACC_IMM8,      // IN/OUT port imm8
        CLS_SINGLE,        // No operand bytes
        CLS_ILLEGAL
    } op_class_t;

endpackage

// ==== src/opcode_classifier.sv ====
// ****************************************
// Opcode classifier
// Sorts an 8086 opcode byte into its class
// ****************************************
`timescale 1ns/1ps

module opcode_classifier import decode_pkg::*;
(
    input  logic [OPCODE_W-1:0] opcode,
    output op_class_t           op_class,
    output logic                illegal
);

    always_comb
    begin
        op_class = CLS_ILLEGAL;
        illegal  = 1'b0;
        casez (opcode)
            8'h0f:                 // POP CS is not supported
            begin
                op_class = CLS_ILLEGAL;
                illegal  = 1'b1;
            end
            8'b00??_?0??:
                op_class = CLS_ALU_RM;
            8'b00??_?10?:
                op_class = CLS_ALU_ACC_IMM;
            8'b00??_?11?:          // PUSH/POP sreg, prefixes, decimal adjust
                op_class = CLS_SINGLE;
            8'b010?_????:
                op_class = CLS_REG16;
            8'b0111_????:          // Jcc
                op_class = CLS_BR_SHORT;
            8'b1000_00??:
                op_class = CLS_GRP1_RM_IMM;
            8'b1000_01??:
                op_class = CLS_TEST_XCHG_RM;
            8'b1000_10??:
                op_class = CLS_MOV_RM;
            8'b1000_11?0:
                op_class = CLS_MOV_SREG;
            8'h8d:
                op_class = CLS_LEA;
            8'h8f:
                op_class = CLS_POP_RM;
            8'b1001_0???:          // NOP and XCHG ACC,reg16
                op_class = CLS_REG16;
            8'h9a:                 // CALL far
                op_class = CLS_BR_FAR;
            8'b1001_1???:          // CBW, CWD, WAIT, flag moves
                op_class = CLS_SINGLE;
            8'b1010_00??:
                op_class = CLS_MOV_ACC_MEM;
            8'b1010_01??,
            8'b1010_101?,
            8'b1010_11??:          // String operations
                op_class = CLS_SINGLE;
            8'b1011_????:
                op_class = CLS_MOV_R_IMM;
            8'b1100_000?:
                op_class = CLS_SHIFT_RM_IMM;
            8'hc2:
                op_class = CLS_RET_IMM;
            8'hc3:
                op_class = CLS_SINGLE;
            8'b1100_011?:
                op_class = CLS_MOV_RM_IMM;
            8'b1101_00??:
                op_class = CLS_SHIFT_RM;
            8'b1110_01??:
                op_class = CLS_ACC_IMM8;
            8'b1110_100?:          // CALL and JMP near
                op_class = CLS_BR_NEAR;
            8'hea:
                op_class = CLS_BR_FAR;
            8'heb:
                op_class = CLS_BR_SHORT;
            8'hf3,                 // REP
            8'hfa,                 // CLI
            8'hfc:                 // CLD
                op_class = CLS_SINGLE;
            default:
            begin
                op_class = CLS_ILLEGAL;
                illegal  = 1'b1;
            end
        endcase
    end

    // The flag is set apart from the class in the case above
    always_comb
    begin
        if (!$isunknown(opcode))
        begin
            assert (illegal == (op_class == CLS_ILLEGAL))
            else $error("illegal flag disagrees with class for opcode %h", opcode);
        end
    end

endmodule

// ==== src/operand_select.sv ====
// ****************************************
// Operand select
// Format fields and register ids from class and ModR/M
// ****************************************
`timescale 1ns/1ps

module operand_select import decode_pkg::*;
(
    input  op_class_t           op_class,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [MODRM_W-1:0]  modrm,
    output logic                need_modrm,
    output logic                need_disp,
    output logic                disp_size,   // 0 for 8 bits, 1 for 16 bits
    output logic                need_imm,
    output logic                imm_size,    // 0 for 8 bits, 1 for 16 bits
    output logic                byte_word,
    output reg_id_t             src,
    output reg_id_t             dst
);

    logic [1:0] mod;
    logic [2:0] reg_fld;
    logic [2:0] rm;
    logic [2:0] dstm;
    logic [2:0] srcm;
    logic       direct;
    logic       disp_mod;
    logic       disp16_mod;

    assign mod     = modrm[7:6];
    assign reg_fld = modrm[5:3];
    assign rm      = modrm[2:0];

    // D bit picks which ModR/M field is the destination
    assign dstm = opcode[1] ? reg_fld : rm;
    assign srcm = opcode[1] ? rm : reg_fld;

    assign direct     = (mod == 2'b00) && (rm == MODRM_DIRECT_RM);
    assign disp_mod   = direct || ((mod != 2'b00) && (mod != MOD_REG));
    assign disp16_mod = direct || (mod == 2'b10);

    always_comb
    begin
        need_modrm = 1'b0;
        need_disp  = 1'b0;
        disp_size  = 1'b0;
        need_imm   = 1'b0;
        imm_size   = 1'b0;
        byte_word  = opcode[0];
        src        = '0;
        dst        = '0;

        case (op_class)
            CLS_ALU_RM, CLS_TEST_XCHG_RM, CLS_MOV_RM:
            begin
                src = {1'b0, srcm};
                dst = {1'b0, dstm};
            end
            CLS_MOV_SREG:
            begin
                src       = {~opcode[1], srcm};   // Sreg on the side the D bit names
                dst       = {opcode[1], dstm};
                byte_word = opcode[3];
            end
            CLS_ALU_ACC_IMM, CLS_MOV_RM_IMM:
            begin
                need_imm = 1'b1;
                imm_size = opcode[0];
            end
            CLS_GRP1_RM_IMM:
            begin
                need_imm = 1'b1;
                imm_size = (opcode[1:0] == 2'b01);  // Only 81 takes imm16
            end
            CLS_MOV_R_IMM:
            begin
                need_imm  = 1'b1;
                imm_size  = opcode[3];
                byte_word = opcode[3];
                dst       = {1'b0, opcode[2:0]};
            end
            CLS_SHIFT_RM_IMM, CLS_ACC_IMM8:
                need_imm = 1'b1;
            CLS_RET_IMM:
            begin
                need_imm = 1'b1;
                imm_size = 1'b1;
            end
            CLS_BR_SHORT:
                need_disp = 1'b1;
            CLS_BR_NEAR, CLS_MOV_ACC_MEM:
            begin
                need_disp = 1'b1;
                disp_size = 1'b1;
            end
            CLS_BR_FAR:                           // Offset as disp, segment as imm
            begin
                need_disp = 1'b1;
                disp_size = 1'b1;
                need_imm  = 1'b1;
                imm_size  = 1'b1;
            end
            CLS_REG16:
                src = {1'b0, opcode[2:0]};
            CLS_ILLEGAL:
                byte_word = 1'b0;
            default:
                ;
        endcase

        // Register ids and displacement of the ModR/M forms
        case (op_class)
            CLS_ALU_RM, CLS_TEST_XCHG_RM, CLS_MOV_RM, CLS_MOV_SREG,
            CLS_GRP1_RM_IMM, CLS_MOV_RM_IMM, CLS_LEA, CLS_POP_RM,
            CLS_SHIFT_RM, CLS_SHIFT_RM_IMM:
            begin
                need_modrm = 1'b1;
                need_disp  = disp_mod;
                disp_size  = disp_mod && disp16_mod;
            end
            default:
                ;
        endcase

        case (op_class)
            CLS_LEA:
                dst = {1'b0, reg_fld};
            CLS_POP_RM, CLS_GRP1_RM_IMM, CLS_MOV_RM_IMM:
                dst = {1'b0, rm};
            CLS_SHIFT_RM, CLS_SHIFT_RM_IMM:
            begin
                src = {1'b0, rm};
                dst = {1'b0, rm};
            end
            default:
                ;
        endcase
    end

    // Sized displacement only with a displacement present
    always_comb
    begin
        if (!$isunknown({op_class, opcode, modrm}))
        begin
            assert (!disp_size || need_disp)
            else $error("disp_size set without need_disp, opcode %h", opcode);
        end
    end

endmodule

// ==== src/insn_length.sv ====
// ****************************************
// Instruction length
// Byte count from the format fields
// ****************************************
`timescale 1ns/1ps

module insn_length import decode_pkg::*;
(
    input  logic      need_modrm,
    input  logic      need_disp,
    input  logic      disp_size,
    input  logic      need_imm,
    input  logic      imm_size,
    output insn_len_t insn_len
);

    insn_len_t disp_bytes;
    insn_len_t imm_bytes;

    assign disp_bytes = need_disp ? (disp_size ? 3'd2 : 3'd1) : 3'd0;
    assign imm_bytes  = need_imm ? (imm_size ? 3'd2 : 3'd1) : 3'd0;

    // Opcode byte always counts
    assign insn_len = 3'd1 + {2'b00, need_modrm} + disp_bytes + imm_bytes;

    always_comb
    begin
        if (!$isunknown({need_modrm, need_disp, disp_size, need_imm, imm_size}))
        begin
            assert ((insn_len >= 3'd1) && (int'(insn_len) <= MAX_INSN_LEN))
            else $error("instruction length %0d out of range", insn_len);
        end
    end

endmodule

// ==== src/decode_stage.sv ====
// ****************************************
// Decode pipeline stage
// STAGES deep register chain for valid and fields
// ****************************************
`timescale 1ns/1ps

module decode_stage import decode_pkg::*;
#(
    parameter int unsigned STAGES = 1
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  logic      illegal,
    input  logic      need_modrm,
    input  logic      need_disp,
    input  logic      disp_size,
    input  logic      need_imm,
    input  logic      imm_size,
    input  logic      byte_word,
    input  reg_id_t   src,
    input  reg_id_t   dst,
    input  insn_len_t insn_len,
    output logic      out_valid,
    output logic      illegal_q,
    output logic      need_modrm_q,
    output logic      need_disp_q,
    output logic      disp_size_q,
    output logic      need_imm_q,
    output logic      imm_size_q,
    output logic      byte_word_q,
    output reg_id_t   src_q,
    output reg_id_t   dst_q,
    output insn_len_t insn_len_q
);

    localparam int FIELD_W = 7 + 2 * $bits(reg_id_t) + $bits(insn_len_t);

    logic [FIELD_W-1:0] in_data;
    logic [FIELD_W-1:0] data_q [STAGES];
    logic               valid_q [STAGES];

    assign in_data = {illegal, need_modrm, need_disp, disp_size, need_imm, imm_size,
                      byte_word, src, dst, insn_len};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < STAGES; i++)
            begin
                valid_q[i] <= 1'b0;
                data_q[i]  <= '0;            // Outputs read zero after reset
            end
        end
        else
        begin
            valid_q[0] <= in_valid;
            if (in_valid)
                data_q[0] <= in_data;
            for (int i = 1; i < STAGES; i++)
            begin
                valid_q[i] <= valid_q[i-1];
                if (valid_q[i-1])            // Hold the last item through gaps
                    data_q[i] <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[STAGES-1];
    assign {illegal_q, need_modrm_q, need_disp_q, disp_size_q, need_imm_q, imm_size_q,
            byte_word_q, src_q, dst_q, insn_len_q} = data_q[STAGES-1];

    out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
    else $error("out_valid unknown after reset");

endmodule

// ==== src/decode_top.sv ====
// ****************************************
// 8086 decoder top level
// Registered instruction format decode
// ****************************************
`timescale 1ns/1ps

module decode_top import decode_pkg::*;
#(
    parameter int unsigned STAGES = 1
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [MODRM_W-1:0]  modrm,   // Only read for ModR/M classes
    output logic                out_valid,
    output logic                need_modrm,
    output logic                need_disp,
    output logic                disp_size,
    output logic                need_imm,
    output logic                imm_size,
    output reg_id_t             src,
    output reg_id_t             dst,
    output logic                byte_word,
    output insn_len_t           insn_len,
    output logic                illegal
);

    op_class_t op_class;
    logic      dec_illegal;
    logic      dec_need_modrm;
    logic      dec_need_disp;
    logic      dec_disp_size;
    logic      dec_need_imm;
    logic      dec_imm_size;
    logic      dec_byte_word;
    reg_id_t   dec_src;
    reg_id_t   dec_dst;
    insn_len_t dec_insn_len;

    opcode_classifier opcode_classifier_inst (
        .opcode   (opcode),
        .op_class (op_class),
        .illegal  (dec_illegal)
    );

    operand_select operand_select_inst (
        .op_class   (op_class),
        .opcode     (opcode),
        .modrm      (modrm),
        .need_modrm (dec_need_modrm),
        .need_disp  (dec_need_disp),
        .disp_size  (dec_disp_size),
        .need_imm   (dec_need_imm),
        .imm_size   (dec_imm_size),
        .byte_word  (dec_byte_word),
        .src        (dec_src),
        .dst        (dec_dst)
    );

    insn_length insn_length_inst (
        .need_modrm (dec_need_modrm),
        .need_disp  (dec_need_disp),
        .disp_size  (dec_disp_size),
        .need_imm   (dec_need_imm),
        .imm_size   (dec_imm_size),
        .insn_len   (dec_insn_len)
    );

    decode_stage #(
        .STAGES (STAGES)
    ) decode_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .illegal      (dec_illegal),
        .need_modrm   (dec_need_modrm),
        .need_disp    (dec_need_disp),
        .disp_size    (dec_disp_size),
        .need_imm     (dec_need_imm),
        .imm_size     (dec_imm_size),
        .byte_word    (dec_byte_word),
        .src          (dec_src),
        .dst          (dec_dst),
        .insn_len     (dec_insn_len),
        .out_valid    (out_valid),
        .illegal_q    (illegal),
        .need_modrm_q (need_modrm),
        .need_disp_q  (need_disp),
        .disp_size_q  (disp_size),
        .need_imm_q   (need_imm),
        .imm_size_q   (imm_size),
        .byte_word_q  (byte_word),
        .src_q        (src),
        .dst_q        (dst),
        .insn_len_q   (insn_len)
    );

endmodule

// ==== bench/decode_checks.svh ====
// ****************************************
// Reference decode model and compare tasks
// ****************************************
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsr_state = 32'ha2983170;
int          check_count = 0;
int          error_count = 0;

logic      exp_illegal;
logic      exp_need_modrm;
logic      exp_need_disp;
logic      exp_disp_size;
logic      exp_need_imm;
logic      exp_imm_size;
logic      exp_byte_word;
reg_id_t   exp_src;
reg_id_t   exp_dst;
insn_len_t exp_len;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
endfunction

function automatic op_class_t ref_class(input logic [7:0] op);
    if (op == 8'h0f)
        return CLS_ILLEGAL;
    if (op < 8'h40)                                   // ALU block with its odd columns
        return (op[2:1] == 2'b11) ? CLS_SINGLE : (op[2] ? CLS_ALU_ACC_IMM : CLS_ALU_RM);
    case (op) inside
        [8'h40:8'h5f], [8'h90:8'h97]: return CLS_REG16;
        [8'h70:8'h7f], 8'heb:         return CLS_BR_SHORT;
        [8'h80:8'h83]:                return CLS_GRP1_RM_IMM;
        [8'h84:8'h87]:                return CLS_TEST_XCHG_RM;
        [8'h88:8'h8b]:                return CLS_MOV_RM;
        8'h8c, 8'h8e:                 return CLS_MOV_SREG;
        8'h8d:                        return CLS_LEA;
        8'h8f:                        return CLS_POP_RM;
        8'h9a, 8'hea:                 return CLS_BR_FAR;
        [8'ha0:8'ha3]:                return CLS_MOV_ACC_MEM;
        [8'hb0:8'hbf]:                return CLS_MOV_R_IMM;
        8'hc0, 8'hc1:                 return CLS_SHIFT_RM_IMM;
        8'hc2:                        return CLS_RET_IMM;
        8'hc6, 8'hc7:                 return CLS_MOV_RM_IMM;
        [8'hd0:8'hd3]:                return CLS_SHIFT_RM;
        [8'he4:8'he7]:                return CLS_ACC_IMM8;
        8'he8, 8'he9:                 return CLS_BR_NEAR;
        [8'h98:8'h9f], [8'ha4:8'ha7], [8'haa:8'haf], 8'hc3, 8'hf3, 8'hfa, 8'hfc:
            return CLS_SINGLE;
        default:                      return CLS_ILLEGAL;
    endcase
endfunction

task automatic clear_expect();
    {exp_illegal, exp_need_modrm, exp_need_disp, exp_disp_size} = '0;
    {exp_need_imm, exp_imm_size, exp_byte_word} = '0;
    exp_src = '0;
    exp_dst = '0;
    exp_len = '0;
endtask

task automatic ref_decode(input logic [7:0] op, input logic [7:0] mrm);
    op_class_t  cls;
    logic [1:0] md;
    logic [2:0] rg;
    logic [2:0] rm;
    logic       direct;
    cls    = ref_class(op);
    md     = mrm[7:6];
    rg     = mrm[5:3];
    rm     = mrm[2:0];
    direct = (md == 2'b00) && (rm == MODRM_DIRECT_RM);
    exp_illegal    = (cls == CLS_ILLEGAL);
    exp_need_modrm = cls inside {CLS_ALU_RM, CLS_TEST_XCHG_RM, CLS_MOV_RM, CLS_MOV_SREG,
                                 CLS_GRP1_RM_IMM, CLS_MOV_RM_IMM, CLS_LEA, CLS_POP_RM,
                                 CLS_SHIFT_RM, CLS_SHIFT_RM_IMM};
    exp_need_disp  = exp_need_modrm && (direct || (md == 2'b01) || (md == 2'b10));
    exp_disp_size  = exp_need_modrm && (direct || (md == 2'b10));
    if (cls inside {CLS_BR_SHORT, CLS_BR_NEAR, CLS_BR_FAR, CLS_MOV_ACC_MEM})
    begin
        exp_need_disp = 1'b1;
        exp_disp_size = (cls != CLS_BR_SHORT);           // Only Jcc and JMP short use disp8
    end
    exp_need_imm = cls inside {CLS_ALU_ACC_IMM, CLS_MOV_RM_IMM, CLS_GRP1_RM_IMM, CLS_MOV_R_IMM,
                               CLS_SHIFT_RM_IMM, CLS_ACC_IMM8, CLS_RET_IMM, CLS_BR_FAR};
    case (cls)
        CLS_ALU_ACC_IMM, CLS_MOV_RM_IMM: exp_imm_size = op[0];
        CLS_GRP1_RM_IMM:                 exp_imm_size = (op == 8'h81);
        CLS_MOV_R_IMM:                   exp_imm_size = op[3];
        CLS_RET_IMM, CLS_BR_FAR:         exp_imm_size = 1'b1;
        default:                         exp_imm_size = 1'b0;
    endcase
    if (exp_illegal)
        exp_byte_word = 1'b0;
    else
        exp_byte_word = (cls inside {CLS_MOV_R_IMM, CLS_MOV_SREG}) ? op[3] : op[0];
    exp_src = '0;
    exp_dst = '0;
    case (cls)
        CLS_ALU_RM, CLS_TEST_XCHG_RM, CLS_MOV_RM, CLS_MOV_SREG:
        begin
            exp_dst = {1'b0, (op[1] ? rg : rm)};
            exp_src = {1'b0, (op[1] ? rm : rg)};
            if (cls == CLS_MOV_SREG)
            begin
                exp_dst[3] = op[1];                      // Segment side follows D
                exp_src[3] = !op[1];
            end
        end
        CLS_LEA:                                      exp_dst = {1'b0, rg};
        CLS_POP_RM, CLS_GRP1_RM_IMM, CLS_MOV_RM_IMM: exp_dst = {1'b0, rm};
        CLS_SHIFT_RM, CLS_SHIFT_RM_IMM:
        begin
            exp_src = {1'b0, rm};
            exp_dst = {1'b0, rm};
        end
        CLS_REG16:                                    exp_src = {1'b0, op[2:0]};
        CLS_MOV_R_IMM:                                exp_dst = {1'b0, op[2:0]};
        default:
            ;
    endcase
    exp_len = 3'd1 + {2'b00, exp_need_modrm}
            + (exp_need_disp ? (exp_disp_size ? 3'd2 : 3'd1) : 3'd0)
            + (exp_need_imm ? (exp_imm_size ? 3'd2 : 3'd1) : 3'd0);
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Error %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_reg(input string what, input reg_id_t got, input reg_id_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Error %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_len(input string what, input insn_len_t got, input insn_len_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Error %0d ns: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic compare_outputs(input logic [7:0] op, input logic [7:0] mrm);
    string tag;
    tag = $sformatf("opcode %h modrm %h", op, mrm);
    check_flag({tag, " illegal"}, illegal, exp_illegal);
    check_flag({tag, " need_modrm"}, need_modrm, exp_need_modrm);
    check_flag({tag, " need_disp"}, need_disp, exp_need_disp);
    check_flag({tag, " disp_size"}, disp_size, exp_disp_size);
    check_flag({tag, " need_imm"}, need_imm, exp_need_imm);
    check_flag({tag, " imm_size"}, imm_size, exp_imm_size);
    check_flag({tag, " byte_word"}, byte_word, exp_byte_word);
    check_reg({tag, " src"}, src, exp_src);
    check_reg({tag, " dst"}, dst, exp_dst);
    check_len({tag, " insn_len"}, insn_len, exp_len);
endtask

`endif

// ==== bench/decode_tb.sv ====
// ****************************************
// 8086 decoder testbench
// Directed tests against a reference decode model
// ****************************************
`timescale 1ns/1ps

module decode_tb import decode_pkg::*;
();

    localparam int STAGES      = 1;
    localparam int CLK_PERIOD  = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int WAIT_LIMIT  = 8;          // Cycles allowed for out_valid
    localparam int RM_PER_MOD  = 4;
    localparam int N_STREAM    = 64;
    // Reset, R/M forms, immediates, branches, illegal, stream
    localparam int N_VECTORS   = 5 + 51 + 32 + 18 + 10 + N_STREAM + 2;
    localparam int WATCHDOG_NS = (2 * N_VECTORS + 50) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    logic [7:0] opcode;
    logic [7:0] modrm;
    logic       out_valid;
    logic       need_modrm;
    logic       need_disp;
    logic       disp_size;
    logic       need_imm;
    logic       imm_size;
    reg_id_t    src;
    reg_id_t    dst;
    logic       byte_word;
    insn_len_t  insn_len;
    logic       illegal;

    `include "decode_checks.svh"

    decode_top #(
        .STAGES (STAGES)
    ) decode_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .opcode     (opcode),
        .modrm      (modrm),
        .out_valid  (out_valid),
        .need_modrm (need_modrm),
        .need_disp  (need_disp),
        .disp_size  (disp_size),
        .need_imm   (need_imm),
        .imm_size   (imm_size),
        .src        (src),
        .dst        (dst),
        .byte_word  (byte_word),
        .insn_len   (insn_len),
        .illegal    (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // One strobe, then wait for its result
    task automatic run_vector(input logic [7:0] op, input logic [7:0] mrm);
        int waited;
        in_valid = 1'b1;
        opcode   = op;
        modrm    = mrm;
        next_cycle();
        in_valid = 1'b0;
        waited   = 1;
        while (!out_valid && (waited < WAIT_LIMIT))
        begin
            next_cycle();
            waited++;
        end
        if (!out_valid)
        begin
            error_count++;
            $display("No out_valid within %0d cycles for opcode %h", WAIT_LIMIT, op);
        end
        else
        begin
            ref_decode(op, mrm);
            compare_outputs(op, mrm);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("Test %s: %s, %0d errors", name,
                 (error_count == start_errors) ? "ok" : "failed", error_count - start_errors);
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = error_count;
        clear_expect();
        next_cycle();
        check_flag("reset out_valid", out_valid, 1'b0);
        compare_outputs(opcode, modrm);
        next_cycle();
        rst_n = 1'b1;                        // Two edges in reset
        repeat (3)
        begin
            next_cycle();
            check_flag("idle out_valid", out_valid, 1'b0);
            compare_outputs(opcode, modrm);
        end
        report_test("reset", start_errors);
    endtask

    task automatic test_rm_forms();
        int          start_errors;
        logic [31:0] r;
        start_errors = error_count;
        for (int m = 0; m < 4; m++)
        begin
            for (int k = 0; k < RM_PER_MOD; k++)
            begin
                r = rand_bits(11);
                run_vector({2'b00, r[4:2], 1'b0, r[1:0]}, {m[1:0], r[10:5]});
                r = rand_bits(8);
                run_vector({6'b100010, r[7:6]}, {m[1:0], r[5:0]});
                r = rand_bits(7);
                run_vector(r[6] ? 8'h8e : 8'h8c, {m[1:0], r[5:0]});
            end
        end
        run_vector(8'h01, 8'h06);            // Direct addressing
        run_vector(8'h8b, 8'h1e);
        run_vector(8'h8c, 8'h06);
        report_test("rm_forms", start_errors);
    endtask

    task automatic test_imm_forms();
        int          start_errors;
        logic [31:0] r;
        logic [7:0]  ops [$];
        start_errors = error_count;
        ops = '{8'h04, 8'h05, 8'h0c, 8'h2d, 8'h3c, 8'h80, 8'h81, 8'h83,
                8'hc6, 8'hc7, 8'hc0, 8'hc1, 8'hd0, 8'hd1, 8'hd2, 8'hd3};
        foreach (ops[i])
        begin
            r = rand_bits(8);
            run_vector(ops[i], r[7:0]);
        end
        for (int k = 0; k < 16; k++)
        begin
            r = rand_bits(8);
            run_vector(8'hb0 + 8'(k), r[7:0]);
        end
        report_test("imm_forms", start_errors);
    endtask

    task automatic test_branches();
        int          start_errors;
        logic [31:0] r;
        logic [7:0]  ops [$];
        start_errors = error_count;
        ops = '{8'h70, 8'h75, 8'h7f, 8'heb, 8'he9, 8'he8, 8'h9a, 8'hea, 8'hc2,
                8'ha0, 8'ha1, 8'ha2, 8'ha3, 8'he4, 8'he5, 8'he6, 8'he7, 8'hc3};
        foreach (ops[i])
        begin
            r = rand_bits(8);
            run_vector(ops[i], r[7:0]);      // ModR/M is ignored here
        end
        report_test("branches", start_errors);
    endtask

    task automatic test_illegal();
        int          start_errors;
        logic [31:0] r;
        logic [7:0]  ops [$];
        start_errors = error_count;
        ops = '{8'h0f, 8'hd8, 8'hf4, 8'h60, 8'hc4, 8'hc5, 8'hc8, 8'ha8, 8'he0, 8'hff};
        foreach (ops[i])
        begin
            r = rand_bits(8);
            run_vector(ops[i], r[7:0]);
        end
        report_test("illegal", start_errors);
    endtask

    // Random strobes with gaps, each result exactly one edge later
    task automatic test_stream();
        int          start_errors;
        logic [31:0] r;
        logic        busy;
        logic [7:0]  last_op;
        logic [7:0]  last_mrm;
        start_errors = error_count;
        last_op  = opcode;
        last_mrm = modrm;
        busy     = 1'b0;
        next_cycle();
        for (int i = 0; i < N_STREAM; i++)
        begin
            check_flag($sformatf("stream cycle %0d out_valid", i), out_valid, busy);
            compare_outputs(last_op, last_mrm);
            r    = rand_bits(2);
            busy = (r[1:0] != 2'b00);
            do
            begin
                r = rand_bits(16);
            end while (ref_class(r[15:8]) == CLS_ILLEGAL);
            in_valid = busy;
            opcode   = r[15:8];              // Also changes during gaps
            modrm    = r[7:0];
            if (busy)
            begin
                last_op  = r[15:8];
                last_mrm = r[7:0];
                ref_decode(last_op, last_mrm);
            end
            next_cycle();
        end
        in_valid = 1'b0;
        check_flag("stream end out_valid", out_valid, busy);
        compare_outputs(last_op, last_mrm);
        report_test("stream", start_errors);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        opcode   = 8'h05;
        modrm    = 8'hc3;
        test_reset();
        test_rm_forms();
        test_imm_forms();
        test_branches();
        test_illegal();
        test_stream();
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+bench
src/decode_pkg.sv
src/opcode_classifier.sv
src/operand_select.sv
src/insn_length.sv
src/decode_stage.sv
src/decode_top.sv
bench/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
verilator --binary --timing -f filelist.f --top-module decode_tb -o decode_sim > build.log 2>&1 \
    && ./obj_dir/decode_sim > sim.log 2>&1 \
    && grep -qx ">>> PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
